/* source/scaler_pkg.sv */
/*
  Shared widths, line timing and APB register map of the line doubler.
  Timing assumes a fixed 64-pixel input line with a 40-pixel active window.
*/
`default_nettype none

package scaler_pkg;

  ////////////////////////////////////////////////////////////
  // pixel format and line buffer
  ////////////////////////////////////////////////////////////
  localparam int unsigned COLOR_W_I = 7;
  localparam int unsigned COLOR_W_O = 8;
  localparam int unsigned BUF_PAGES = 4;
  localparam int unsigned PAGE_W    = 2;
  // flat buffer address over all pages
  localparam int unsigned BUF_AW    = 8;

  ////////////////////////////////////////////////////////////
  // line timing, counted in input pixels
  ////////////////////////////////////////////////////////////
  localparam int unsigned H_TOTAL  = 64;
  localparam int unsigned H_START  = 16;
  localparam int unsigned H_ACTIVE = 40;
  localparam int unsigned HCNT_W   = 7;
  // output sync widths
  localparam int unsigned HS_WIDTH = 6;
  localparam int unsigned VS_LINES = 4;
  localparam int unsigned VCNT_W   = 3;

  ////////////////////////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////////////////////////
  localparam logic [3:0] REG_CTRL_ADDR = 4'h0;
  localparam logic [3:0] REG_STR_ADDR  = 4'h4;
  // control register fields
  localparam int unsigned CTRL_DBL_EN = 0;
  localparam int unsigned CTRL_SL_EN  = 1;
  localparam int unsigned CTRL_SL_ID  = 2;

endpackage

`default_nettype wire

/* source/scaler_regs.sv */
/*
  APB slave with two settings registers; pready is tied high.
  Unmapped addresses flag pslverr, store nothing and read zero.
*/
`timescale 1ns/1ps
`default_nettype none

module scaler_regs
  import scaler_pkg::*;
(
  input  wire         VCLK_Tx,
  input  wire         nRST,
  input  wire  [3:0]  paddr_i,
  input  wire         psel_i,
  input  wire         penable_i,
  input  wire         pwrite_i,
  input  wire  [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        dbl_en_o,
  output logic        sl_en_o,
  output logic        sl_id_o,
  output logic [3:0]  sl_str_o
);

  logic       apb_access;
  logic       hit_ctrl;
  logic       hit_str;
  logic [2:0] ctrl_q;
  logic [3:0] str_q;

  // access phase is psel and penable together
  assign apb_access = psel_i & penable_i;
  assign hit_ctrl   = paddr_i == REG_CTRL_ADDR;
  assign hit_str    = paddr_i == REG_STR_ADDR;

  always_ff @(posedge VCLK_Tx) begin
    if (!nRST) begin
      ctrl_q <= '0;
      str_q  <= '0;
    end else if (apb_access && pwrite_i) begin
      if (hit_ctrl) begin
        ctrl_q <= pwdata_i[2:0];
      end
      if (hit_str) begin
        str_q <= pwdata_i[3:0];
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    if (apb_access && !pwrite_i) begin
      if (hit_ctrl) begin
        prdata_o = {29'd0, ctrl_q};
      end else if (hit_str) begin
        prdata_o = {28'd0, str_q};
      end
    end
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = apb_access & ~(hit_ctrl | hit_str);

  assign dbl_en_o = ctrl_q[CTRL_DBL_EN];
  assign sl_en_o  = ctrl_q[CTRL_SL_EN];
  assign sl_id_o  = ctrl_q[CTRL_SL_ID];
  assign sl_str_o = str_q;

endmodule

`default_nettype wire

/* source/line_writer.sv */
/*
  Input side of the doubler. Syncs and pixels are taken on pix_en_i only.
  Lines shorter than H_START+H_ACTIVE pixels are dropped without a page step.
*/
`timescale 1ns/1ps
`default_nettype none

module line_writer
  import scaler_pkg::*;
(
  input  wire               VCLK_Tx,
  input  wire               nRST,
  input  wire               pix_en_i,
  input  wire               hsync_n_i,
  input  wire               vsync_n_i,
  output logic              wr_en_o,
  output logic [PAGE_W-1:0] wr_page_o,
  output logic [HCNT_W-1:0] wr_addr_o,
  output logic              line_done_o,
  output logic [PAGE_W-1:0] line_page_o,
  output logic              frame_start_o
);

  logic              hs_q;
  logic              vs_q;
  logic              line_open;
  logic [HCNT_W-1:0] hcnt;
  logic [HCNT_W-1:0] cnt_now;
  logic              hs_fall;
  logic              vs_fall;
  logic              in_window;
  logic              line_full;

  assign hs_fall = pix_en_i & hs_q & ~hsync_n_i;
  assign vs_fall = pix_en_i & vs_q & ~vsync_n_i;

  // count of the pixel on the pins, 0 at the hsync edge, saturating
  assign cnt_now   = hs_fall ? '0 : ((&hcnt) ? hcnt : hcnt + 1'b1);
  assign in_window = (cnt_now >= HCNT_W'(H_START)) &&
                     (cnt_now < HCNT_W'(H_START + H_ACTIVE));
  assign line_full = line_open && (hcnt >= HCNT_W'(H_START + H_ACTIVE - 1));

  // pixel data goes to the buffer straight from the pins
  assign wr_en_o   = pix_en_i & line_open & in_window;
  assign wr_addr_o = cnt_now - HCNT_W'(H_START);

  always_ff @(posedge VCLK_Tx) begin
    if (!nRST) begin
      hs_q          <= 1'b1;
      vs_q          <= 1'b1;
      line_open     <= 1'b0;
      hcnt          <= '0;
      wr_page_o     <= '0;
      line_done_o   <= 1'b0;
      line_page_o   <= '0;
      frame_start_o <= 1'b0;
    end else begin
      line_done_o   <= 1'b0;
      frame_start_o <= vs_fall;
      if (pix_en_i) begin
        hs_q <= hsync_n_i;
        vs_q <= vsync_n_i;
        hcnt <= cnt_now;
      end
      if (hs_fall) begin
        line_open <= 1'b1;
        // close the page only when the whole window was written
        if (line_full) begin
          line_done_o <= 1'b1;
          line_page_o <= wr_page_o;
          wr_page_o   <= (wr_page_o == PAGE_W'(BUF_PAGES - 1)) ? '0 : wr_page_o + 1'b1;
        end
      end
      if (vs_fall) begin
        wr_page_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/line_buffer.sv */
/*
  Multi-page RGB line memory, one write and one read port.
  Read data appears one clock after the read address.
*/
`timescale 1ns/1ps
`default_nettype none

module line_buffer
  import scaler_pkg::*;
(
  input  wire                  VCLK_Tx,
  input  wire                  wr_en_i,
  input  wire [PAGE_W-1:0]     wr_page_i,
  input  wire [HCNT_W-1:0]     wr_addr_i,
  input  wire [COLOR_W_I-1:0]  wr_r_i,
  input  wire [COLOR_W_I-1:0]  wr_g_i,
  input  wire [COLOR_W_I-1:0]  wr_b_i,
  input  wire [PAGE_W-1:0]     rd_page_i,
  input  wire [HCNT_W-1:0]     rd_addr_i,
  output logic [COLOR_W_I-1:0] rd_r_o,
  output logic [COLOR_W_I-1:0] rd_g_o,
  output logic [COLOR_W_I-1:0] rd_b_o
);

  logic [3*COLOR_W_I-1:0] mem [BUF_PAGES*H_ACTIVE];
  logic [BUF_AW-1:0]      wr_idx;
  logic [BUF_AW-1:0]      rd_idx;

  // pages sit back to back, H_ACTIVE words each
  assign wr_idx = BUF_AW'(wr_page_i) * BUF_AW'(H_ACTIVE) + BUF_AW'(wr_addr_i);
  assign rd_idx = BUF_AW'(rd_page_i) * BUF_AW'(H_ACTIVE) + BUF_AW'(rd_addr_i);

  always_ff @(posedge VCLK_Tx) begin
    if (wr_en_i) begin
      mem[wr_idx] <= {wr_r_i, wr_g_i, wr_b_i};
    end
    {rd_r_o, rd_g_o, rd_b_o} <= mem[rd_idx];
  end

endmodule

`default_nettype wire

/* source/line_reader.sv */
/*
  Replays each closed page twice at full clock rate, one line per H_TOTAL clocks.
  Holds at most one waiting page; a further line_done overwrites it.
*/
`timescale 1ns/1ps
`default_nettype none

module line_reader
  import scaler_pkg::*;
(
  input  wire               VCLK_Tx,
  input  wire               nRST,
  input  wire               line_done_i,
  input  wire [PAGE_W-1:0]  line_page_i,
  input  wire               frame_start_i,
  output logic [PAGE_W-1:0] rd_page_o,
  output logic [HCNT_W-1:0] rd_addr_o,
  output logic              rd_de_o,
  output logic              copy_id_o,
  output logic              rd_hs_n_o,
  output logic              rd_vs_n_o
);

  logic              active;
  logic              pend;
  logic [PAGE_W-1:0] pend_page;
  logic [HCNT_W-1:0] hcnt;
  logic              copy_q;
  logic              fs_pend;
  logic [VCNT_W-1:0] vcnt;
  logic              line_end;
  logic              take;
  logic [PAGE_W-1:0] take_page;
  logic              new_page;
  logic              line_start;
  logic              in_window;

  assign line_end  = active && (hcnt == HCNT_W'(H_TOTAL - 1));
  assign take      = pend | line_done_i;
  assign take_page = pend ? pend_page : line_page_i;
  // a page is taken when idle or once its predecessor's second copy ends
  assign new_page   = take && (!active || (line_end && copy_q));
  assign line_start = new_page || (line_end && !copy_q);

  always_ff @(posedge VCLK_Tx) begin
    if (!nRST) begin
      active    <= 1'b0;
      pend      <= 1'b0;
      pend_page <= '0;
      hcnt      <= '0;
      copy_q    <= 1'b0;
      rd_page_o <= '0;
      fs_pend   <= 1'b0;
      vcnt      <= VCNT_W'(VS_LINES);
    end else begin
      if (line_done_i && !(new_page && !pend)) begin
        pend      <= 1'b1;
        pend_page <= line_page_i;
      end else if (new_page) begin
        pend <= 1'b0;
      end

      if (new_page) begin
        active    <= 1'b1;
        rd_page_o <= take_page;
        copy_q    <= 1'b0;
        hcnt      <= '0;
      end else if (line_end) begin
        hcnt <= '0;
        if (copy_q) begin
          active <= 1'b0;
        end else begin
          copy_q <= 1'b1;
        end
      end else if (active) begin
        hcnt <= hcnt + 1'b1;
      end

      ////////////////////////////////////////////////////////////
      // output line count, restarted at the first line after a frame start
      ////////////////////////////////////////////////////////////
      if (frame_start_i) begin
        fs_pend <= 1'b1;
      end
      if (line_start) begin
        if (fs_pend || frame_start_i) begin
          vcnt    <= '0;
          fs_pend <= 1'b0;
        end else if (vcnt != VCNT_W'(VS_LINES)) begin
          vcnt <= vcnt + 1'b1;
        end
      end
    end
  end

  assign in_window = active && (hcnt >= HCNT_W'(H_START)) &&
                     (hcnt < HCNT_W'(H_START + H_ACTIVE));

  // address parks at zero outside the window
  assign rd_de_o   = in_window;
  assign rd_addr_o = in_window ? hcnt - HCNT_W'(H_START) : '0;
  assign copy_id_o = copy_q;
  assign rd_hs_n_o = !(active && (hcnt < HCNT_W'(HS_WIDTH)));
  assign rd_vs_n_o = vcnt >= VCNT_W'(VS_LINES);

endmodule

`default_nettype wire

/* source/scanline_shader.sv */
/*
  Output stage. Doubled path is three clocks from reader address to de_o,
  bypass is two clocks from the input pins. Colours widen 7 to 8 bits.
*/
`timescale 1ns/1ps
`default_nettype none

module scanline_shader
  import scaler_pkg::*;
(
  input  wire                  VCLK_Tx,
  input  wire                  nRST,
  input  wire                  dbl_en_i,
  input  wire                  sl_en_i,
  input  wire                  sl_id_i,
  input  wire [3:0]            sl_str_i,
  input  wire [COLOR_W_I-1:0]  rd_r_i,
  input  wire [COLOR_W_I-1:0]  rd_g_i,
  input  wire [COLOR_W_I-1:0]  rd_b_i,
  input  wire                  rd_de_i,
  input  wire                  copy_id_i,
  input  wire                  rd_hs_n_i,
  input  wire                  rd_vs_n_i,
  input  wire                  pix_en_i,
  input  wire                  hsync_n_i,
  input  wire                  vsync_n_i,
  input  wire [COLOR_W_I-1:0]  r_i,
  input  wire [COLOR_W_I-1:0]  g_i,
  input  wire [COLOR_W_I-1:0]  b_i,
  output logic [COLOR_W_O-1:0] r_o,
  output logic [COLOR_W_O-1:0] g_o,
  output logic [COLOR_W_O-1:0] b_o,
  output logic                 de_o,
  output logic                 hsync_n_o,
  output logic                 vsync_n_o
);

  logic                 de_d1, de_d2, hs_d1, hs_d2, vs_d1, vs_d2;
  logic                 copy_d1;
  logic                 shade_d2;
  logic [COLOR_W_O-1:0] r_d2, g_d2, b_d2;
  logic [COLOR_W_O-1:0] sl_fac;
  logic                 hs_q;
  logic [HCNT_W-1:0]    hcnt;
  logic [HCNT_W-1:0]    cnt_now;
  logic                 in_window;
  logic                 byp_de, byp_hs, byp_vs;
  logic [COLOR_W_O-1:0] byp_r, byp_g, byp_b;

  // replicate the top bit into the new lsb
  function automatic logic [COLOR_W_O-1:0] widen(input logic [COLOR_W_I-1:0] c);
    return {c, c[COLOR_W_I-1]};
  endfunction

  function automatic logic [COLOR_W_O-1:0] shade(input logic [COLOR_W_O-1:0] c,
                                                 input logic [COLOR_W_O-1:0] fac);
    logic [2*COLOR_W_O-1:0] prod;
    prod = c * fac;
    return prod[2*COLOR_W_O-1:COLOR_W_O];
  endfunction

  // 255 - ((str+1)*16 - 1)
  assign sl_fac = 8'hff - {sl_str_i, 4'hf};

  // input pixel count for the bypass window, same rule as the writer
  assign cnt_now   = (pix_en_i & hs_q & ~hsync_n_i) ? '0 :
                     ((&hcnt) ? hcnt : hcnt + 1'b1);
  assign in_window = (cnt_now >= HCNT_W'(H_START)) &&
                     (cnt_now < HCNT_W'(H_START + H_ACTIVE));

  always_ff @(posedge VCLK_Tx) begin
    if (!nRST) begin
      {de_d1, de_d2, copy_d1, shade_d2} <= '0;
      {hs_d1, hs_d2, vs_d1, vs_d2}      <= '1;
      hs_q      <= 1'b1;
      hcnt      <= '0;
      byp_de    <= 1'b0;
      byp_hs    <= 1'b1;
      byp_vs    <= 1'b1;
      de_o      <= 1'b0;
      hsync_n_o <= 1'b1;
      vsync_n_o <= 1'b1;
    end else begin
      // control waits one clock for the buffer read
      de_d1    <= rd_de_i;
      hs_d1    <= rd_hs_n_i;
      vs_d1    <= rd_vs_n_i;
      copy_d1  <= copy_id_i;
      de_d2    <= de_d1;
      hs_d2    <= hs_d1;
      vs_d2    <= vs_d1;
      shade_d2 <= sl_en_i && (copy_d1 == sl_id_i);
      if (pix_en_i) begin
        hs_q <= hsync_n_i;
        hcnt <= cnt_now;
      end
      byp_de <= pix_en_i && in_window;
      byp_hs <= hsync_n_i;
      byp_vs <= vsync_n_i;
      de_o      <= dbl_en_i ? de_d2 : byp_de;
      hsync_n_o <= dbl_en_i ? hs_d2 : byp_hs;
      vsync_n_o <= dbl_en_i ? vs_d2 : byp_vs;
    end
  end

  ////////////////////////////////////////////////////////////
  // colour path
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK_Tx) begin
    r_d2  <= de_d1 ? widen(rd_r_i) : '0;
    g_d2  <= de_d1 ? widen(rd_g_i) : '0;
    b_d2  <= de_d1 ? widen(rd_b_i) : '0;
    byp_r <= widen(r_i);
    byp_g <= widen(g_i);
    byp_b <= widen(b_i);
    if (!dbl_en_i) begin
      r_o <= byp_r;
      g_o <= byp_g;
      b_o <= byp_b;
    end else if (shade_d2) begin
      r_o <= shade(r_d2, sl_fac);
      g_o <= shade(g_d2, sl_fac);
      b_o <= shade(b_d2, sl_fac);
    end else begin
      r_o <= r_d2;
      g_o <= g_d2;
      b_o <= b_d2;
    end
  end

endmodule

`default_nettype wire

/* source/scaler_top.sv */
/*
  Line doubler top: APB registers, writer, buffer, reader and shader.
  Single clock VCLK_Tx; after reset the design is in bypass.
*/
`timescale 1ns/1ps
`default_nettype none

module scaler_top
  import scaler_pkg::*;
(
  input  wire                  VCLK_Tx,
  input  wire                  nRST,
  input  wire                  pix_en_i,
  input  wire                  hsync_n_i,
  input  wire                  vsync_n_i,
  input  wire [COLOR_W_I-1:0]  r_i,
  input  wire [COLOR_W_I-1:0]  g_i,
  input  wire [COLOR_W_I-1:0]  b_i,
  input  wire [3:0]            paddr_i,
  input  wire                  psel_i,
  input  wire                  penable_i,
  input  wire                  pwrite_i,
  input  wire [31:0]           pwdata_i,
  output logic [31:0]          prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  output logic [COLOR_W_O-1:0] r_o,
  output logic [COLOR_W_O-1:0] g_o,
  output logic [COLOR_W_O-1:0] b_o,
  output logic                 de_o,
  output logic                 hsync_n_o,
  output logic                 vsync_n_o
);

  logic                 dbl_en, sl_en, sl_id;
  logic [3:0]           sl_str;
  logic                 wr_en, line_done, frame_start;
  logic [PAGE_W-1:0]    wr_page, line_page, rd_page;
  logic [HCNT_W-1:0]    wr_addr, rd_addr;
  logic                 rd_de, copy_id, rd_hs_n, rd_vs_n;
  logic [COLOR_W_I-1:0] rd_r, rd_g, rd_b;

  scaler_regs u_regs (
    .VCLK_Tx, .nRST, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .dbl_en_o(dbl_en), .sl_en_o(sl_en), .sl_id_o(sl_id), .sl_str_o(sl_str)
  );

  // pipeline: writer -> buffer -> reader -> shader
  line_writer u_writer (
    .VCLK_Tx, .nRST, .pix_en_i, .hsync_n_i, .vsync_n_i,
    .wr_en_o(wr_en), .wr_page_o(wr_page), .wr_addr_o(wr_addr),
    .line_done_o(line_done), .line_page_o(line_page), .frame_start_o(frame_start)
  );

  line_buffer u_buffer (
    .VCLK_Tx, .wr_en_i(wr_en), .wr_page_i(wr_page), .wr_addr_i(wr_addr),
    .wr_r_i(r_i), .wr_g_i(g_i), .wr_b_i(b_i), .rd_page_i(rd_page), .rd_addr_i(rd_addr),
    .rd_r_o(rd_r), .rd_g_o(rd_g), .rd_b_o(rd_b)
  );

  line_reader u_reader (
    .VCLK_Tx, .nRST, .line_done_i(line_done), .line_page_i(line_page),
    .frame_start_i(frame_start), .rd_page_o(rd_page), .rd_addr_o(rd_addr),
    .rd_de_o(rd_de), .copy_id_o(copy_id), .rd_hs_n_o(rd_hs_n), .rd_vs_n_o(rd_vs_n)
  );

  scanline_shader u_shader (
    .VCLK_Tx, .nRST, .dbl_en_i(dbl_en), .sl_en_i(sl_en), .sl_id_i(sl_id),
    .sl_str_i(sl_str), .rd_r_i(rd_r), .rd_g_i(rd_g), .rd_b_i(rd_b), .rd_de_i(rd_de),
    .copy_id_i(copy_id), .rd_hs_n_i(rd_hs_n), .rd_vs_n_i(rd_vs_n),
    .pix_en_i, .hsync_n_i, .vsync_n_i, .r_i, .g_i, .b_i,
    .r_o, .g_o, .b_o, .de_o, .hsync_n_o, .vsync_n_o
  );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
/*
  Testbench clock and reset: 8 ns period, nRST low for four clocks,
  released on a falling edge.
*/
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/scaler_tb.sv */
/*
  Testbench for the line doubler. Records come from bench/scaler_stimulus.txt.
  Register changes and frames are run one after the other, never overlapped.
  Doubled frames need at least 3 lines so the output vsync can close.
*/
`timescale 1ns/1ps
`default_nettype none

module scaler_tb
  import scaler_pkg::*;
();

  wire               VCLK_Tx;
  wire               nRST;
  logic              pix_en;
  logic              hsync_n;
  logic              vsync_n;
  logic [6:0]        r_in;
  logic [6:0]        g_in;
  logic [6:0]        b_in;
  logic [3:0]        paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [31:0]       prdata_o;
  logic              pready_o;
  logic              pslverr_o;
  logic [7:0]        r_o;
  logic [7:0]        g_o;
  logic [7:0]        b_o;
  logic              de_o;
  logic              hsync_n_o;
  logic              vsync_n_o;

  byte               cmd_q[$];
  logic [31:0]       arg1_q[$];
  logic [31:0]       arg2_q[$];
  logic [31:0]       arg3_q[$];
  logic [23:0]       exp_q[$];
  logic [31:0]       seed = 32'h42e7c3f0;
  logic [2:0]        ctrl_shadow = '0;
  logic [3:0]        str_shadow = '0;
  int                errors = 0;
  int                checks = 0;
  int                limit_clocks = 0;
  int                hs_falls = 0;
  int                vs_low = 0;
  int                run_len = 0;
  int                gap_len = 0;
  logic              hs_prev = 1'b1;

  clock_gen u_clk (.clk_o(VCLK_Tx), .rst_n_o(nRST));

  scaler_top uut (
    .VCLK_Tx, .nRST, .pix_en_i(pix_en), .hsync_n_i(hsync_n), .vsync_n_i(vsync_n),
    .r_i(r_in), .g_i(g_in), .b_i(b_in), .paddr_i(paddr), .psel_i(psel),
    .penable_i(penable), .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o, .pready_o,
    .pslverr_o, .r_o, .g_o, .b_o, .de_o, .hsync_n_o, .vsync_n_o
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected output pixel for a stored {r,g,b} word on a shaded or plain copy
  function automatic logic [23:0] expect_pixel(input logic [20:0] raw, input logic dark,
                                               input logic [3:0] str);
    int          fac;
    int          ch;
    logic [23:0] res;
    fac = 255 - ((int'(str) + 1) * 16 - 1);
    res = '0;
    for (int c = 0; c < 3; c++) begin
      ch = int'(raw[c*7 +: 7]);
      ch = ch * 2 + ch / 64;
      if (dark) begin
        ch = ch * fac / 256;
      end
      res[c*8 +: 8] = ch[7:0];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_access(input logic [3:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int wait_cnt;
    @(negedge VCLK_Tx);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge VCLK_Tx);
    penable  = 1'b1;
    wait_cnt = 0;
    @(posedge VCLK_Tx);
    while (!pready_o && wait_cnt < 16) begin
      wait_cnt++;
      @(posedge VCLK_Tx);
    end
    if (!pready_o) begin
      $display("ERROR: APB access to address %h never completed", addr);
      errors++;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge VCLK_Tx);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // one pixel spans two clocks with pix_en high in the second
  task automatic send_pixel(input logic hs_n, input logic vs_n, input logic [20:0] rgb);
    @(negedge VCLK_Tx);
    pix_en  = 1'b0;
    hsync_n = hs_n;
    vsync_n = vs_n;
    {r_in, g_in, b_in} = rgb;
    @(negedge VCLK_Tx);
    pix_en = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // one frame of video followed by a closing hsync edge and drain
  ////////////////////////////////////////////////////////////
  task automatic send_frame(input int lines);
    logic [20:0] raw [H_ACTIVE];
    logic [20:0] rgb;
    logic        dbl;
    int          hs_base;
    int          vs_base;
    int          wait_cnt;
    int          idx;
    dbl     = ctrl_shadow[0];
    hs_base = hs_falls;
    vs_base = vs_low;
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < int'(H_TOTAL); p++) begin
        seed = lcg_next(seed);
        rgb  = {seed[30:24], seed[22:16], seed[14:8]};
        if (p >= int'(H_START) && p < int'(H_START + H_ACTIVE)) begin
          idx      = p - int'(H_START);
          raw[idx] = rgb;
          // bypass output follows the pins within a few clocks
          if (!dbl) begin
            exp_q.push_back(expect_pixel(rgb, 1'b0, str_shadow));
          end
        end
        send_pixel(p >= 4, l != 0, rgb);
      end
      if (dbl) begin
        for (int k = 0; k < int'(H_ACTIVE); k++) begin
          exp_q.push_back(expect_pixel(raw[k], ctrl_shadow[1] && !ctrl_shadow[2], str_shadow));
        end
        for (int k = 0; k < int'(H_ACTIVE); k++) begin
          exp_q.push_back(expect_pixel(raw[k], ctrl_shadow[1] && ctrl_shadow[2], str_shadow));
        end
      end
    end
    // hsync edge that closes the last line before hsync returns high
    send_pixel(1'b0, 1'b1, '0);
    send_pixel(1'b1, 1'b1, '0);
    @(negedge VCLK_Tx);
    pix_en   = 1'b0;
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 4 * int'(H_TOTAL)) begin
      @(negedge VCLK_Tx);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d expected output pixels (%0d lines) never appeared",
               exp_q.size(), exp_q.size() / int'(H_ACTIVE));
      errors++;
      exp_q.delete();
    end
    repeat (2 * H_TOTAL + 16) @(negedge VCLK_Tx);
    if (dbl) begin
      check_value("hsync_n_o falls", 32'(hs_falls - hs_base), 32'(2 * lines));
      check_value("vsync_n_o low clocks", 32'(vs_low - vs_base), VS_LINES * H_TOTAL);
    end else begin
      // bypass syncs follow the pins, closing edge included
      check_value("hsync_n_o falls", 32'(hs_falls - hs_base), 32'(lines + 1));
      check_value("vsync_n_o low clocks", 32'(vs_low - vs_base), 2 * H_TOTAL);
    end
  endtask

  // gathers de_o runs and ends a line after a gap of 8 clocks
  initial begin
    forever begin
      @(negedge VCLK_Tx);
      if (nRST) begin
        if (hs_prev && !hsync_n_o) begin
          hs_falls++;
        end
        hs_prev = hsync_n_o;
        if (!vsync_n_o) begin
          vs_low++;
        end
        if (de_o) begin
          if (run_len == 0 && exp_q.size() == 0) begin
            $display("ERROR: output line appeared with no line expected");
            errors++;
          end
          if (exp_q.size() != 0) begin
            check_value("{r_o,g_o,b_o}", 32'({r_o, g_o, b_o}), 32'(exp_q.pop_front()));
          end
          run_len++;
          gap_len = 0;
        end else if (run_len != 0) begin
          gap_len++;
          if (gap_len == 8) begin
            if (run_len != int'(H_ACTIVE)) begin
              $display("ERROR: output line had %0d pixels instead of %0d", run_len, H_ACTIVE);
              errors++;
            end
            run_len = 0;
          end
        end
      end
    end
  end

  initial begin
    wait (limit_clocks != 0);
    repeat (limit_clocks) @(posedge VCLK_Tx);
    $display("ERROR: watchdog expired after %0d clocks", limit_clocks);
    $display("Regression failed");
    $finish;
  end

  initial begin
    int          fd;
    int          n;
    int          total_lines;
    int          frames;
    string       line;
    byte         code;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    logic [31:0] rdata;
    logic        err;
    pix_en  = 1'b0;
    hsync_n = 1'b1;
    vsync_n = 1'b1;
    r_in    = '0;
    g_in    = '0;
    b_in    = '0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    total_lines = 0;
    frames      = 0;
    fd = $fopen("bench/scaler_stimulus.txt", "r");
    if (fd == 0) begin
      $display("ERROR: stimulus file bench/scaler_stimulus.txt could not be opened");
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (line.len() > 1) begin
        code = line.getc(0);
        a1   = '0;
        a2   = '0;
        a3   = '0;
        n    = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a1, a2, a3);
        if (code == "W" || code == "R" || code == "F") begin
          cmd_q.push_back(code);
          arg1_q.push_back(a1);
          arg2_q.push_back(a2);
          arg3_q.push_back(a3);
          if (code == "F") begin
            total_lines += int'(a1);
            frames++;
          end
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    limit_clocks = 2 * int'(H_TOTAL) * (total_lines + 4 * frames) + 2000;

    wait (nRST == 1'b1);
    @(negedge VCLK_Tx);
    // outputs idle and APB ready straight after reset
    check_value("de_o", 32'(de_o), 32'd0);
    check_value("hsync_n_o", 32'(hsync_n_o), 32'd1);
    check_value("vsync_n_o", 32'(vsync_n_o), 32'd1);
    check_value("pready_o", 32'(pready_o), 32'd1);
    check_value("pslverr_o", 32'(pslverr_o), 32'd0);
    for (int i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "W": begin
          apb_access(arg1_q[i][3:0], 1'b1, arg2_q[i], rdata, err);
          if (arg1_q[i][3:0] == REG_CTRL_ADDR) begin
            ctrl_shadow = arg2_q[i][2:0];
          end else if (arg1_q[i][3:0] == REG_STR_ADDR) begin
            str_shadow = arg2_q[i][3:0];
          end
        end
        "R": begin
          apb_access(arg1_q[i][3:0], 1'b0, '0, rdata, err);
          check_value("prdata_o", rdata, arg2_q[i]);
          check_value("pslverr_o", 32'(err), 32'(arg3_q[i][0]));
        end
        default: begin
          send_frame(int'(arg1_q[i]));
        end
      endcase
    end

    repeat (16) @(negedge VCLK_Tx);
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
source/scaler_pkg.sv
source/scaler_regs.sv
source/line_writer.sv
source/line_buffer.sv
source/line_reader.sv
source/scanline_shader.sv
source/scaler_top.sv
bench/clock_gen.sv
bench/scaler_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the line doubler testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module scaler_tb -f vlog.f -o scaler_sim

./obj_dir/scaler_sim | tee sim.log

# the log decides the result, not the simulator's exit status
if grep -q "^Regression passed$" sim.log; then
  echo "simulation result: pass"
  exit 0
fi
echo "simulation result: fail"
exit 1

/* bench/scaler_stimulus.txt */
# one record per line, all numbers hex
# W addr data | R addr expect_data expect_err | F lines_in_frame
R 0 0 0
R 4 0 0
R 8 0 1
F 3
W 4 a
W 0 1
R 4 a 0
R 0 1 0
W 8 ff
R 0 1 0
F 5
W 4 0
W 0 3
F 4
W 4 f
F 3
W 0 7
F 4
W 4 0
F 3
W 0 0
R 0 0 0
F 2
